// ==== sim/egress_stim.txt ====
// Fields in hex, one record per line: test_port_bytes_last_ovf_gap_data
// ovf marks a test that expects overflow; data byte 0 is the rightmost pair
1_0_10_1_0_02_0f0e0d0c_0b0a0908_07060504_03020100
1_2_10_1_0_02_1f1e1d1c_1b1a1918_17161514_13121110
2_1_10_0_0_00_2f2e2d2c_2b2a2928_27262524_23222120
2_1_05_1_0_02_3f3e3d3c_3b3a3938_37363534_33323130
2_3_10_0_0_00_4f4e4d4c_4b4a4948_47464544_43424140
2_3_05_1_0_02_5f5e5d5c_5b5a5958_57565554_53525150
3_0_10_1_0_01_6f6e6d6c_6b6a6968_67666564_63626160
3_1_10_1_0_01_7f7e7d7c_7b7a7978_77767574_73727170
3_2_10_1_0_01_8f8e8d8c_8b8a8988_87868584_83828180
3_3_10_1_0_01_9f9e9d9c_9b9a9998_97969594_93929190
3_0_10_1_0_01_afaeadac_abaaa9a8_a7a6a5a4_a3a2a1a0
3_1_10_1_0_01_bfbebdbc_bbbab9b8_b7b6b5b4_b3b2b1b0
3_2_10_1_0_01_cfcecdcc_cbcac9c8_c7c6c5c4_c3c2c1c0
3_3_10_1_0_01_dfdedddc_dbdad9d8_d7d6d5d4_d3d2d1d0
4_0_10_1_1_00_e1e1e1e1_e1e1e1e1_e1e1e1e1_e1e1e1e1
4_0_10_1_1_00_e2e2e2e2_e2e2e2e2_e2e2e2e2_e2e2e2e2
4_0_10_1_1_00_e3e3e3e3_e3e3e3e3_e3e3e3e3_e3e3e3e3
4_0_10_1_1_00_e4e4e4e4_e4e4e4e4_e4e4e4e4_e4e4e4e4
4_0_10_1_1_00_e5e5e5e5_e5e5e5e5_e5e5e5e5_e5e5e5e5
4_0_10_1_1_00_e6e6e6e6_e6e6e6e6_e6e6e6e6_e6e6e6e6
4_0_10_1_1_00_e7e7e7e7_e7e7e7e7_e7e7e7e7_e7e7e7e7
4_0_10_1_1_04_e8e8e8e8_e8e8e8e8_e8e8e8e8_e8e8e8e8
5_4_10_1_0_03_f3f2f1f0_f7f6f5f4_fbfaf9f8_fffefdfc
5_7_10_1_0_03_0c0d0e0f_08090a0b_04050607_00010203

// ==== tb.f ====
design/egress_bus_pkg.sv
design/egress_port_pkg.sv
design/egress_port_decode.sv
design/egress_port_buffer.sv
design/egress_width_adapt.sv
design/p4_router_egress.sv
sim/tb_p4_router_egress.sv

// ==== Bender.yml ====
package:
  name: p4_router_egress

sources:
  # Packages first, then the stages and the top level
  - files:
      - design/egress_bus_pkg.sv
      - design/egress_port_pkg.sv
      - design/egress_port_decode.sv
      - design/egress_port_buffer.sv
      - design/egress_width_adapt.sv
      - design/p4_router_egress.sv

  - target: simulation
    files:
      - sim/tb_p4_router_egress.sv

// ==== sim/tb_p4_router_egress.sv ====
// Testbench for the router egress stage; replays sim/egress_stim.txt record by record.
// Expected narrow beats come from the slicing rule and are checked as each strobe fires.
`timescale 1ns/100ps

module tb_p4_router_egress;

    import egress_bus_pkg::*;
    import egress_port_pkg::*;

    localparam int N4      = 2;
    localparam int N8      = 2;
    localparam int NP      = N4 + N8;
    localparam int TIMEOUT = 2000;

    logic          clk = 1'b0;
    logic          rst_n;
    egr_sel_beat_t egr_bus;
    logic          egr_valid;
    port_4b_beat_t out_4b [N4];
    logic [N4-1:0] valid_4b;
    port_8b_beat_t out_8b [N8];
    logic [N8-1:0] valid_8b;
    logic [N4-1:0] ovf_4b;
    logic [N8-1:0] ovf_8b;
    logic          bad_drop;
    logic [NP-1:0] valid_all;
    logic [NP-1:0] ovf_all;

    logic [159:0] stim [64];

    // Expected narrow beats per port as {data, keep, last}, zero extended to 8 bytes
    logic [72:0]  exp_beat [NP][256];
    logic         exp_live [NP][256];
    int           wr_idx [NP];
    int           rd_idx [NP];
    int           exp_left;

    // Per wide beat: cycle of its buffer write, first queue entry, slice count
    int           beat_tag [NP][64];
    int           beat_first [NP][64];
    int           beat_n [NP][64];
    int           beat_cnt [NP];

    int           cyc = 0;
    int           sent [NP];
    int           ovf_seen [NP];
    int           out_seen [NP];
    int           bad_seen;
    int           bad_exp;
    int           ovf_exp;
    int           errors;

    assign valid_all = {valid_8b, valid_4b};
    assign ovf_all   = {ovf_8b, ovf_4b};

    always #10 clk = ~clk;

    p4_router_egress #(
        .NUM_4B_PORTS        ( N4        ),
        .NUM_8B_PORTS        ( N8        ),
        .BUF_DEPTH           ( 4         )
    ) i_dut (
        .clk                 ( clk       ),
        .rst_n               ( rst_n     ),
        .egr_bus             ( egr_bus   ),
        .egr_valid           ( egr_valid ),
        .egr_4b_ports        ( out_4b    ),
        .egr_4b_valid        ( valid_4b  ),
        .egr_8b_ports        ( out_8b    ),
        .egr_8b_valid        ( valid_8b  ),
        .egr_4b_buf_overflow ( ovf_4b    ),
        .egr_8b_buf_overflow ( ovf_8b    ),
        .bad_port_drop       ( bad_drop  )
    );

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic string port_name(input int p, input string kind);
        if (p < N4) begin
            return $sformatf("egr_4b_%s[%0d]", kind, p);
        end
        return $sformatf("egr_8b_%s[%0d]", kind, p - N4);
    endfunction

    function automatic logic [72:0] port_out(input int p);
        if (p < N4) begin
            return {32'h0, out_4b[p].data, 4'h0, out_4b[p].keep, out_4b[p].last};
        end
        return {out_8b[p-N4].data, out_8b[p-N4].keep, out_8b[p-N4].last};
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Slices of ob bytes, byte 0 first, last only on the final slice
    task automatic predict(input int p, input logic [127:0] data, input logic [15:0] keep,
                           input logic last, input int nbytes);
        int          ob;
        int          n;
        logic [63:0] d;
        logic [7:0]  k;
        ob = (p < N4) ? 4 : 8;
        n  = (nbytes + ob - 1) / ob;
        // Write lands two edges after the drive
        beat_tag[p][beat_cnt[p]]   = cyc + 2;
        beat_first[p][beat_cnt[p]] = wr_idx[p];
        beat_n[p][beat_cnt[p]]     = n;
        beat_cnt[p]++;
        for (int s = 0; s < n; s++) begin
            d = '0;
            k = '0;
            for (int b = 0; b < ob; b++) begin
                d[b*8 +: 8] = data[(s*ob+b)*8 +: 8];
                k[b]        = keep[s*ob+b];
            end
            exp_beat[p][wr_idx[p]] = {d, k, last && (s == n - 1)};
            exp_live[p][wr_idx[p]] = 1'b1;
            wr_idx[p]++;
            exp_left++;
        end
    endtask

    // A full buffer discards the beat whose write lands on the pulse's edge
    task automatic drop_beat(input int p);
        int hit;
        hit = 0;
        for (int k = 0; k < beat_cnt[p]; k++) begin
            if (beat_tag[p][k] == cyc && exp_live[p][beat_first[p][k]]) begin
                for (int s = 0; s < beat_n[p][k]; s++) begin
                    exp_live[p][beat_first[p][k] + s] = 1'b0;
                    exp_left--;
                end
                hit = 1;
            end
        end
        if (hit == 0) begin
            $display("Overflow on %s matches no beat that was sent", port_name(p, "ports"));
            errors++;
        end
    endtask

    task automatic compare_out(input int p);
        while (rd_idx[p] < wr_idx[p] && !exp_live[p][rd_idx[p]]) begin
            rd_idx[p]++;
        end
        if (rd_idx[p] == wr_idx[p]) begin
            $display("%s produced a beat that was not expected", port_name(p, "ports"));
            errors++;
        end else begin
            check(port_name(p, "ports"), port_out(p), exp_beat[p][rd_idx[p]]);
            exp_live[p][rd_idx[p]] = 1'b0;
            rd_idx[p]++;
            exp_left--;
        end
        out_seen[p]++;
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (ovf_all[p]) begin
                    ovf_seen[p]++;
                    drop_beat(p);
                end
            end
            for (int p = 0; p < NP; p++) begin
                if (valid_all[p]) begin
                    compare_out(p);
                end
            end
            if (bad_drop) begin
                bad_seen++;
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Called on a falling edge; holds the beat for one cycle, then idles for the gap
    task automatic drive_record(input logic [159:0] rec);
        int          p;
        int          nbytes;
        logic [15:0] keep;
        p      = rec[155:152];
        nbytes = rec[151:144];
        keep   = (nbytes >= 16) ? 16'hffff : 16'((32'h1 << nbytes) - 1);
        egr_bus.port      = rec[154:152];
        egr_bus.beat.data = rec[127:0];
        egr_bus.beat.keep = keep;
        egr_bus.beat.last = rec[140];
        egr_valid         = 1'b1;
        if (p < NP) begin
            predict(p, rec[127:0], keep, rec[140], nbytes);
            sent[p]++;
        end else begin
            bad_exp++;
        end
        if (rec[136]) begin
            ovf_exp = 1;
        end
        @(negedge clk);
        egr_valid = 1'b0;
        repeat (rec[135:128]) @(negedge clk);
    endtask

    task automatic wait_drain(output bit ok);
        int t;
        t = 0;
        while (exp_left != 0 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        ok = (exp_left == 0);
    endtask

    initial begin
        int  i;
        int  test;
        int  err_start;
        int  n_pass;
        int  n_fail;
        bit  ok;
        bit  timed_out;
        n_pass    = 0;
        n_fail    = 0;
        timed_out = 0;
        errors    = 0;
        exp_left  = 0;
        bad_seen  = 0;
        for (int p = 0; p < NP; p++) begin
            wr_idx[p]   = 0;
            rd_idx[p]   = 0;
            beat_cnt[p] = 0;
            ovf_seen[p] = 0;
            out_seen[p] = 0;
        end
        for (int r = 0; r < 64; r++) begin
            stim[r] = '0;
        end
        $readmemh("sim/egress_stim.txt", stim);
        rst_n     = 1'b0;
        egr_valid = 1'b0;
        egr_bus   = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Quiet outputs between reset and the first record
        err_start = errors;
        repeat (4) begin
            @(negedge clk);
            check("valid, overflow and bad_port_drop", {valid_all, ovf_all, bad_drop}, '0);
        end
        $display("Test 0 (idle after reset) %s", (errors == err_start) ? "passed" : "failed");
        if (errors == err_start) n_pass++;
        else n_fail++;

        i = 0;
        while (stim[i][159:156] != 4'h0) begin
            test      = stim[i][159:156];
            err_start = errors;
            bad_seen  = 0;
            bad_exp   = 0;
            ovf_exp   = 0;
            for (int p = 0; p < NP; p++) begin
                sent[p]     = 0;
                ovf_seen[p] = 0;
                out_seen[p] = 0;
            end
            while (stim[i][159:156] == test) begin
                drive_record(stim[i]);
                i++;
            end
            wait_drain(ok);
            if (!ok) begin
                $display("Timeout: outputs of test %0d did not drain in %0d cycles",
                         test, TIMEOUT);
                timed_out = 1;
                break;
            end
            // Room for late flag pulses
            repeat (4) @(negedge clk);
            check("bad_port_drop pulse count", bad_seen, bad_exp);
            for (int p = 0; p < NP; p++) begin
                if (ovf_exp == 0) begin
                    check(port_name(p, "buf_overflow pulse count"), ovf_seen[p], 0);
                end else if (sent[p] > 0) begin
                    if (ovf_seen[p] == 0) begin
                        $display("No overflow seen on %s during the burst", port_name(p, "ports"));
                        errors++;
                    end
                    check(port_name(p, "buf_overflow pulse count"), ovf_seen[p],
                          sent[p] - out_seen[p] / ((p < N4) ? 4 : 2));
                end
            end
            $display("Test %0d %s", test, (errors == err_start) ? "passed" : "failed");
            if (errors == err_start) n_pass++;
            else n_fail++;
        end

        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (timed_out || n_fail != 0 || errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

// ==== design/p4_router_egress.sv ====
// Router egress top level; decodes the port number, buffers per port, narrows to port width.
// Port numbers 0..NUM_4B_PORTS-1 are 4-byte ports, the 8-byte ports follow.
`timescale 1ns/100ps

module p4_router_egress #(
    parameter int NUM_4B_PORTS = 2,
    parameter int NUM_8B_PORTS = 2,
    parameter int BUF_DEPTH    = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  egress_bus_pkg::egr_sel_beat_t  egr_bus,
    input  logic                           egr_valid,
    output egress_port_pkg::port_4b_beat_t egr_4b_ports [NUM_4B_PORTS],
    output logic [NUM_4B_PORTS-1:0]        egr_4b_valid,
    output egress_port_pkg::port_8b_beat_t egr_8b_ports [NUM_8B_PORTS],
    output logic [NUM_8B_PORTS-1:0]        egr_8b_valid,
    output logic [NUM_4B_PORTS-1:0]        egr_4b_buf_overflow,
    output logic [NUM_8B_PORTS-1:0]        egr_8b_buf_overflow,
    output logic                           bad_port_drop
);

    import egress_bus_pkg::*;
    import egress_port_pkg::*;

    localparam int NUM_PORTS = NUM_4B_PORTS + NUM_8B_PORTS;

    // Port number field cannot reach more ports than this
    if (NUM_PORTS > MAX_EGR_PORTS) begin : g_port_count_check
        $error("p4_router_egress: %0d ports exceed the port number range", NUM_PORTS);
    end

    egr_beat_t            dec_beat;
    logic [NUM_PORTS-1:0] wr_strobe;
    egr_beat_t            head [NUM_PORTS];
    logic [NUM_PORTS-1:0] not_empty;
    logic [NUM_PORTS-1:0] pop;
    logic [NUM_PORTS-1:0] overflow;

    //////////////////////////////
    // Decode
    //////////////////////////////

    egress_port_decode #(
        .NUM_PORTS     ( NUM_PORTS     )
    ) i_decode (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .egr_bus       ( egr_bus       ),
        .egr_valid     ( egr_valid     ),
        .beat_out      ( dec_beat      ),
        .wr_strobe     ( wr_strobe     ),
        .bad_port_drop ( bad_port_drop )
    );

    //////////////////////////////
    // Per-port buffers
    //////////////////////////////

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_buf
        egress_port_buffer #(
            .DEPTH     ( BUF_DEPTH    )
        ) i_buffer (
            .clk       ( clk          ),
            .rst_n     ( rst_n        ),
            .wr_beat   ( dec_beat     ),
            .wr_en     ( wr_strobe[p] ),
            .pop       ( pop[p]       ),
            .head      ( head[p]      ),
            .not_empty ( not_empty[p] ),
            .overflow  ( overflow[p]  )
        );
    end

    //////////////////////////////
    // Width adapters
    //////////////////////////////

    for (genvar i = 0; i < NUM_4B_PORTS; i++) begin : g_4b
        egress_width_adapt #(
            .OUT_BYTES  ( PORT_4B_BYTES   ),
            .out_beat_t ( port_4b_beat_t  )
        ) i_adapt (
            .clk        ( clk             ),
            .rst_n      ( rst_n           ),
            .head       ( head[i]         ),
            .not_empty  ( not_empty[i]    ),
            .pop        ( pop[i]          ),
            .port_beat  ( egr_4b_ports[i] ),
            .port_valid ( egr_4b_valid[i] )
        );
    end

    // 8-byte ports sit after the 4-byte ones in the port numbering
    for (genvar i = 0; i < NUM_8B_PORTS; i++) begin : g_8b
        egress_width_adapt #(
            .OUT_BYTES  ( PORT_8B_BYTES              ),
            .out_beat_t ( port_8b_beat_t             )
        ) i_adapt (
            .clk        ( clk                        ),
            .rst_n      ( rst_n                      ),
            .head       ( head[NUM_4B_PORTS+i]       ),
            .not_empty  ( not_empty[NUM_4B_PORTS+i]  ),
            .pop        ( pop[NUM_4B_PORTS+i]        ),
            .port_beat  ( egr_8b_ports[i]            ),
            .port_valid ( egr_8b_valid[i]            )
        );
    end

    assign egr_4b_buf_overflow = overflow[NUM_4B_PORTS-1:0];
    assign egr_8b_buf_overflow = overflow[NUM_PORTS-1:NUM_4B_PORTS];

endmodule

// ==== design/egress_width_adapt.sv ====
// Splits buffered wide beats into narrow beats of one port width, byte 0 first.
// Instantiated once per port with the narrow beat type of that port class.
`timescale 1ns/100ps

module egress_width_adapt #(
    parameter int  OUT_BYTES  = 4,
    parameter type out_beat_t = egress_port_pkg::port_4b_beat_t
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  egress_bus_pkg::egr_beat_t head,
    input  logic                      not_empty,
    output logic                      pop,
    output out_beat_t                 port_beat,
    output logic                      port_valid
);

    import egress_bus_pkg::*;

    localparam int NUM_SLICES = WIDE_BYTES / OUT_BYTES;
    localparam int SLICE_W    = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    egr_beat_t              held;
    logic                   busy;
    logic [SLICE_W-1:0]     slice;
    logic [OUT_BYTES*8-1:0] slice_data;
    logic [OUT_BYTES-1:0]   slice_keep;
    logic                   final_slice;

    //////////////////////////////
    // Slice select
    //////////////////////////////

    always_comb begin
        slice_data = held.data[int'(slice)*OUT_BYTES*8 +: OUT_BYTES*8];
        slice_keep = held.keep[int'(slice)*OUT_BYTES +: OUT_BYTES];

        // Keep is contiguous, so an empty first byte in the next slice ends the beat
        final_slice = 1'b1;
        for (int s = 0; s < NUM_SLICES - 1; s++) begin
            if (int'(slice) == s && held.keep[(s+1)*OUT_BYTES]) begin
                final_slice = 1'b0;
            end
        end
    end

    always_comb begin
        port_beat.data = slice_data;
        port_beat.keep = slice_keep;
        port_beat.last = held.last && final_slice;
    end

    assign port_valid = busy;

    // Fetch only when idle; head is captured on the same edge
    assign pop = !busy && not_empty;

    //////////////////////////////
    // Slice sequencing
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            slice <= '0;
        end else if (pop) begin
            busy  <= 1'b1;
            slice <= '0;
        end else if (busy) begin
            if (final_slice) begin
                busy <= 1'b0;
            end else begin
                slice <= slice + SLICE_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            held <= head;
        end
    end

endmodule

// ==== design/egress_port_buffer.sv ====
// Per-port FIFO of wide beats; a write into a full FIFO is discarded and flagged.
// The head beat is shown combinationally and leaves on the edge where pop is high.
`timescale 1ns/100ps

module egress_port_buffer #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  egress_bus_pkg::egr_beat_t wr_beat,
    input  logic                      wr_en,
    input  logic                      pop,
    output egress_bus_pkg::egr_beat_t head,
    output logic                      not_empty,
    output logic                      overflow
);

    import egress_bus_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    egr_beat_t          mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W:0]     count;
    logic               full;
    logic               do_rd;
    logic               do_wr;

    // Wraps at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign full      = (int'(count) == DEPTH);
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // A pop frees the slot for a write in the same cycle
    assign do_rd = pop && not_empty;
    assign do_wr = wr_en && (!full || do_rd);

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + (PTR_W+1)'(1);
                2'b01:   count <= count - (PTR_W+1)'(1);
                default: count <= count;
            endcase
            overflow <= wr_en && !do_wr;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

endmodule

// ==== design/egress_port_decode.sv ====
// Port number check for the egress stage; one registered write strobe per accepted beat.
// Out-of-range port numbers are dropped and reported on bad_port_drop.
`timescale 1ns/100ps

module egress_port_decode #(
    parameter int NUM_PORTS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  egress_bus_pkg::egr_sel_beat_t egr_bus,
    input  logic                          egr_valid,
    output egress_bus_pkg::egr_beat_t     beat_out,
    output logic [NUM_PORTS-1:0]          wr_strobe,
    output logic                          bad_port_drop
);

    logic [NUM_PORTS-1:0] port_onehot;
    logic                 port_ok;

    //////////////////////////////
    // Port select
    //////////////////////////////

    // All zero when the port number is past the last port
    always_comb begin
        port_onehot = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (int'(egr_bus.port) == p) begin
                port_onehot[p] = 1'b1;
            end
        end
    end

    assign port_ok = |port_onehot;

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_strobe     <= '0;
            bad_port_drop <= 1'b0;
        end else begin
            wr_strobe     <= egr_valid ? port_onehot : '0;
            bad_port_drop <= egr_valid && !port_ok;
        end
    end

    // Payload only, qualified by wr_strobe
    always_ff @(posedge clk) begin
        beat_out <= egr_bus.beat;
    end

endmodule

// ==== design/egress_port_pkg.sv ====
// Narrow physical port beat definitions for the 4-byte and 8-byte port classes.
package egress_port_pkg;

    //////////////////////////////
    // Port classes
    //////////////////////////////

    localparam int PORT_4B_BYTES = 4;
    localparam int PORT_8B_BYTES = 8;

    // Ports reachable through the 3-bit port number field
    localparam int MAX_EGR_PORTS = 8;

    // Byte 0 of the slice sits in data[7:0]
    typedef struct packed {
        logic [PORT_4B_BYTES*8-1:0] data;
        logic [PORT_4B_BYTES-1:0]   keep;
        logic                       last;
    } port_4b_beat_t;

    typedef struct packed {
        logic [PORT_8B_BYTES*8-1:0] data;
        logic [PORT_8B_BYTES-1:0]   keep;
        logic                       last;
    } port_8b_beat_t;

endpackage

// ==== design/egress_bus_pkg.sv ====
// Wide egress bus definitions shared by the decode, buffer and adapter stages.
// Import into module bodies; refer to the types by scoped name in port lists.
package egress_bus_pkg;

    //////////////////////////////
    // Bus geometry
    //////////////////////////////

    // Data bytes per wide beat
    localparam int WIDE_BYTES = 16;

    // Port number field, sized for the largest router build
    localparam int PORT_IDX_W = 3;

    //////////////////////////////
    // Beat types
    //////////////////////////////

    // One beat on the wide bus, port number already removed.
    // Keep is contiguous from byte 0 and is all ones unless last is set.
    typedef struct packed {
        logic [WIDE_BYTES*8-1:0] data;
        logic [WIDE_BYTES-1:0]   keep;
        logic                    last;
    } egr_beat_t;

    // Beat as delivered by the upstream pipeline
    typedef struct packed {
        egr_beat_t               beat;
        logic [PORT_IDX_W-1:0]   port;
    } egr_sel_beat_t;

endpackage
